/* Bender.yml */
package:
  name: rv32i_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/ctrl_pkg.sv
      - src/instr_decoder.sv
      - src/lane_mask.sv
      - src/ctrl_fsm.sv
      - src/ctrl_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/ctrl_assertions.sv
      - bench/tb_ctrl.sv

/* bench/ctrl_assertions.sv */
module ctrl_assertions
(
    input logic               CLK,
    input logic               RES,
    input logic               instr_req,
    input logic               reg_write,
    input logic               data_gnt,
    input ctrl_pkg::mem_req_t dmem
);
    int fail_count = 0;

    // Data request held with its contents until the grant
    req_held: assert property (@(posedge CLK) disable iff (RES)
        dmem.req && !data_gnt |=> dmem.req && $stable(dmem))
    else
    begin
        fail_count++;
        $error("data request changed before its grant");
    end

    fetch_excl: assert property (@(posedge CLK) disable iff (RES)
        !(instr_req && dmem.req))
    else
    begin
        fail_count++;
        $error("instruction and data requests overlap");
    end

    // One register write per instruction at most
    single_write: assert property (@(posedge CLK) disable iff (RES)
        reg_write |=> !reg_write)
    else
    begin
        fail_count++;
        $error("reg_write high in two consecutive cycles");
    end

endmodule

bind ctrl_fsm ctrl_assertions u_assertions
(
    .CLK       (CLK),
    .RES       (RES),
    .instr_req (instr_req),
    .reg_write (reg_write),
    .data_gnt  (data_gnt),
    .dmem      (dmem)
);

/* bench/tb_ctrl.sv */
`include "ctrl_cfg.svh"

module tb_ctrl;
    import ctrl_pkg::*;

    logic                      CLK = 1'b0;
    logic                      RES;
    logic [`CTRL_OPCODE_W-1:0] opcode;
    logic [`CTRL_FUNCT3_W-1:0] funct3;
    logic [`CTRL_OFFSET_W-1:0] offset;
    logic                      instr_gnt;
    logic                      instr_r_valid;
    logic                      data_gnt;
    logic                      data_r_valid;
    logic                      instr_req;
    logic                      pc_enable;
    logic                      pc_jump;
    logic                      reg_write;
    logic                      merge_write;
    datapath_sel_t             dp_sel;
    mem_req_t                  dmem;

    logic [31:0]  seed = 32'he1d03bea;
    instr_class_e exp_cls;
    int           exp_width;
    int           exp_offset;
    bit           exp_split;
    int           n_fetch, n_pc, n_jump, n_write, n_merge, n_req;
    int           igd, ivd, dgd, dvd;          // Responder delays
    bit           fetch_pending, load_pending;
    bit           prev_iwait, prev_dwait, req_sampled;
    mem_req_t     prev_dmem;
    int           cycles;
    bit           busy;

    ctrl_top dut
    (
        .CLK (CLK), .RES (RES), .opcode (opcode), .funct3 (funct3), .offset (offset),
        .instr_gnt (instr_gnt), .instr_r_valid (instr_r_valid),
        .data_gnt (data_gnt), .data_r_valid (data_r_valid),
        .instr_req (instr_req), .pc_enable (pc_enable), .pc_jump (pc_jump),
        .reg_write (reg_write), .merge_write (merge_write), .dp_sel (dp_sel), .dmem (dmem)
    );

    always #10 CLK = ~CLK;

    //////////////////////////////
    // Random numbers and model
    //////////////////////////////
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n;     // Upper bits have the longer period
    endfunction

    function automatic instr_class_e model_class(input logic [6:0] op, input logic [2:0] f3);
        case (op)
            `CTRL_OP_LUI:    return LUI;
            `CTRL_OP_AUIPC:  return AUIPC;
            `CTRL_OP_IMM:    return ALU_IMM;
            `CTRL_OP_REG:    return ALU_REG;
            `CTRL_OP_JAL:    return JAL;
            `CTRL_OP_JALR:   return JALR;
            `CTRL_OP_BRANCH: return BRANCH;
            `CTRL_OP_LOAD:   return (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ? LOAD : ILLEGAL;
            `CTRL_OP_STORE:  return (f3 <= 3'd2) ? STORE : ILLEGAL;
            default:         return ILLEGAL;
        endcase
    endfunction

    // Access width in bytes
    function automatic int model_width(input logic [2:0] f3);
        case (f3[1:0])
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [`CTRL_LANES-1:0] first_lanes(input int off, input int w);
        logic [`CTRL_LANES-1:0] mask;
        int                     i;
        mask = '0;
        for (i = 0; i < `CTRL_LANES; i++)
            if (i >= off && i < off + w) mask[i] = 1'b1;
        return mask;
    endfunction

    function automatic logic [`CTRL_LANES-1:0] second_lanes(input int off, input int w);
        logic [`CTRL_LANES-1:0] mask;
        int                     i;
        mask = '0;
        for (i = 0; i < off + w - `CTRL_LANES; i++)
            mask[i] = 1'b1;                     // Spill into the next word
        return mask;
    endfunction

    function automatic wb_sel_e expected_wb();
        if (exp_cls != LOAD) return WB_ALU;
        return exp_split ? WB_MERGED : WB_MEM;
    endfunction

    // ALU operands of the current class
    function automatic logic [3:0] expected_src();
        case (exp_cls)
            LUI:       return {SRC_A_ZERO, SRC_B_IMM};
            AUIPC:     return {SRC_A_PC, SRC_B_IMM};
            ALU_REG:   return {SRC_A_REG, SRC_B_REG};
            JAL, JALR: return {SRC_A_PC, SRC_B_FOUR};   // Link value
            default:   return {SRC_A_REG, SRC_B_IMM};   // rs1 + imm
        endcase
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string msg);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at time %0t: %s (actual %0h, expected %0h)",
                     $time, msg, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic clear_counters();
        n_fetch = 0;
        n_pc    = 0;
        n_jump  = 0;
        n_write = 0;
        n_merge = 0;
        n_req   = 0;
    endtask

    task automatic finish_instruction();
        compare_value(n_fetch, 1, "instruction fetches per instruction");
        compare_value(n_pc, exp_cls != ILLEGAL, "pc_enable cycles");
        compare_value(n_jump, exp_cls inside {JAL, JALR, BRANCH}, "pc_jump cycles");
        compare_value(n_write, exp_cls inside {LUI, AUIPC, ALU_IMM, ALU_REG, JAL, JALR, LOAD},
                      "reg_write cycles");
        compare_value(n_merge, exp_cls == LOAD && exp_split, "merge_write cycles");
        compare_value(n_req, (exp_cls inside {LOAD, STORE}) ? (exp_split ? 2 : 1) : 0,
                      "data requests");
        clear_counters();
    endtask

    task automatic draw_instruction();
        int         pick;
        logic [6:0] op;
        logic [2:0] f3;
        int         off;
        pick = rand_below(16);
        case (pick)
            0:              op = `CTRL_OP_LUI;
            1:              op = `CTRL_OP_AUIPC;
            2:              op = `CTRL_OP_IMM;
            3:              op = `CTRL_OP_REG;
            4:              op = `CTRL_OP_JAL;
            5:              op = `CTRL_OP_JALR;
            6:              op = `CTRL_OP_BRANCH;
            7, 8, 9, 10:    op = `CTRL_OP_LOAD;
            11, 12, 13, 14: op = `CTRL_OP_STORE;
            default:        op = 7'(rand_below(128)); // Mostly unknown opcodes
        endcase
        f3  = 3'(rand_below(8));
        off = rand_below(4);
        opcode     <= op;
        funct3     <= f3;
        offset     <= 2'(off);
        exp_cls    = model_class(op, f3);
        exp_width  = model_width(f3);
        exp_offset = off;
        exp_split  = (off + exp_width) > `CTRL_LANES;
    endtask

    // Sample at the falling edge and respond at the next rising edge
    task automatic clock_cycle();
        logic next_igrant;
        logic next_ivalid;
        logic next_dgrant;
        logic next_dvalid;
        bit   new_instr;
        next_igrant = 1'b0;
        next_ivalid = 1'b0;
        next_dgrant = 1'b0;
        next_dvalid = 1'b0;
        new_instr   = 1'b0;
        @(negedge CLK);
        if (prev_iwait) compare_value(instr_req, 1, "instr_req dropped before its grant");
        if (prev_dwait) compare_value(dmem, prev_dmem, "data request changed before grant");
        prev_iwait  = instr_req && !instr_gnt;
        prev_dwait  = dmem.req && !data_gnt;
        prev_dmem   = dmem;
        req_sampled = instr_req;
        if (pc_enable) n_pc++;
        if (pc_jump)
        begin
            n_jump++;
            compare_value(pc_enable, 1, "pc_jump without pc_enable");
        end
        if (reg_write)
        begin
            n_write++;
            compare_value(dp_sel.wb_sel, expected_wb(), "wb_sel during reg_write");
            compare_value(dp_sel.pc_base_reg, exp_cls == JALR, "pc_base_reg during reg_write");
            if (exp_cls != LOAD)
            begin
                compare_value({dp_sel.src_a, dp_sel.src_b}, expected_src(),
                              "operand selects during reg_write");
            end
        end
        if (merge_write) n_merge++;
        if (instr_r_valid) n_fetch++;
        // Instruction port
        if (instr_req && instr_gnt)
        begin
            fetch_pending = 1'b1;
            ivd           = rand_below(4);
            igd           = rand_below(4);
        end
        else if (instr_req)
        begin
            if (igd == 0) next_igrant = 1'b1;
            else igd--;
        end
        if (!instr_r_valid && fetch_pending)
        begin
            if (ivd == 0)
            begin
                next_ivalid   = 1'b1;
                new_instr     = 1'b1;
                fetch_pending = 1'b0;
            end
            else ivd--;
        end
        // Data port
        if (dmem.req && data_gnt)
        begin
            compare_value(dmem.we, exp_cls == STORE, "we of data request");
            compare_value(dmem.second, n_req == 1, "second flag of data request");
            compare_value(dmem.be, (n_req == 0) ? first_lanes(exp_offset, exp_width)
                                                : second_lanes(exp_offset, exp_width),
                          "byte enables of data request");
            compare_value({dp_sel.src_a, dp_sel.src_b}, expected_src(),
                          "operand selects of data request");
            n_req++;
            dgd = rand_below(4);
            if (!dmem.we)
            begin
                load_pending = 1'b1;
                dvd          = rand_below(4);
            end
        end
        else if (dmem.req)
        begin
            if (dgd == 0) next_dgrant = 1'b1;
            else dgd--;
        end
        if (!data_r_valid && load_pending)
        begin
            if (dvd == 0)
            begin
                next_dvalid  = 1'b1;
                load_pending = 1'b0;
            end
            else dvd--;
        end
        @(posedge CLK);
        instr_gnt     <= next_igrant;
        instr_r_valid <= next_ivalid;
        data_gnt      <= next_dgrant;
        data_r_valid  <= next_dvalid;
        if (new_instr) draw_instruction();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial
    begin
        RES           = 1'b1;
        opcode        = '0;
        funct3        = '0;
        offset        = '0;
        instr_gnt     = 1'b0;
        instr_r_valid = 1'b0;
        data_gnt      = 1'b0;
        data_r_valid  = 1'b0;
        exp_cls       = ILLEGAL;
        igd           = rand_below(4);
        dgd           = rand_below(4);
        clear_counters();
        repeat (5) @(posedge CLK);
        RES <= 1'b0;
        @(negedge CLK);
        compare_value(instr_req, 1, "instr_req after reset");
        compare_value(pc_enable, 0, "pc_enable after reset");
        compare_value(pc_jump, 0, "pc_jump after reset");
        compare_value(reg_write, 0, "reg_write after reset");
        compare_value(merge_write, 0, "merge_write after reset");
        compare_value(dmem.req, 0, "dmem.req after reset");
        for (int n = 0; n < 300; n++)
        begin
            busy   = 1'b0;
            cycles = 0;
            while (!(busy && req_sampled))
            begin
                clock_cycle();
                if (!req_sampled) busy = 1'b1;
                cycles++;
                if (cycles > 100)
                begin
                    $display("Instruction %0d did not return to fetch within 100 cycles", n);
                    $display("TB FAILED");
                    $fatal(1, "Timeout");
                end
            end
            finish_instruction();
        end
        if (dut.u_fsm.u_assertions.fail_count == 0)
        begin
            $display("TB PASSED");
            $finish;
        end
        else
        begin
            $display("Handshake assertions failed during the run");
            $display("TB FAILED");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

/* sources.f */
+incdir+src
src/ctrl_pkg.sv
src/instr_decoder.sv
src/lane_mask.sv
src/ctrl_fsm.sv
src/ctrl_top.sv
bench/ctrl_assertions.sv
bench/tb_ctrl.sv

/* src/ctrl_cfg.svh */
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// Instruction field widths
`define CTRL_OPCODE_W 7
`define CTRL_FUNCT3_W 3

// Data word geometry
`define CTRL_LANES    4
`define CTRL_OFFSET_W 2

// RV32I base opcodes
`define CTRL_OP_LUI    7'b0110111
`define CTRL_OP_AUIPC  7'b0010111
`define CTRL_OP_IMM    7'b0010011
`define CTRL_OP_REG    7'b0110011
`define CTRL_OP_JAL    7'b1101111
`define CTRL_OP_JALR   7'b1100111
`define CTRL_OP_BRANCH 7'b1100011
`define CTRL_OP_LOAD   7'b0000011
`define CTRL_OP_STORE  7'b0100011

`endif

/* src/ctrl_fsm.sv */
`include "ctrl_cfg.svh"

module ctrl_fsm
(
    input  logic                    CLK,
    input  logic                    RES,
    input  ctrl_pkg::instr_class_e  cls,
    input  logic                    split,
    input  logic [`CTRL_LANES-1:0]  be,
    input  logic                    instr_gnt,
    input  logic                    instr_r_valid,
    input  logic                    data_gnt,
    input  logic                    data_r_valid,
    output logic                    second_phase,
    output logic                    instr_req,
    output logic                    pc_enable,
    output logic                    pc_jump,
    output logic                    reg_write,
    output logic                    merge_write,
    output ctrl_pkg::datapath_sel_t dp_sel,
    output ctrl_pkg::mem_req_t      dmem
);
    import ctrl_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;

    always_ff @(posedge CLK, posedge RES)
    begin
        if (RES)
        begin
            state <= READY;
        end
        else
        begin
            state <= state_next;
        end
    end

    // Second word of a split access
    assign second_phase = (state == LOAD_SECOND) || (state == STORE_DONE);

    //////////////////////////////
    // Next state and outputs
    //////////////////////////////
    always_comb
    begin
        state_next  = state;
        instr_req   = 1'b0;
        pc_enable   = 1'b0;
        pc_jump     = 1'b0;
        reg_write   = 1'b0;
        merge_write = 1'b0;
        dp_sel      = '{SRC_A_REG, SRC_B_REG, WB_ALU, 1'b0};
        dmem        = '0;

        case (state)
            READY:
            begin
                instr_req = 1'b1;
                if (instr_gnt)
                begin
                    state_next = FETCH;
                end
            end
            FETCH:
            begin
                if (instr_r_valid)
                begin
                    state_next = EXECUTE;
                end
            end
            EXECUTE:
            begin
                case (cls)
                    LUI, AUIPC, ALU_IMM, ALU_REG:
                    begin
                        reg_write  = 1'b1;
                        state_next = WRITEBACK;
                        if (cls == LUI)
                        begin
                            dp_sel.src_a = SRC_A_ZERO;
                        end
                        if (cls == AUIPC)
                        begin
                            dp_sel.src_a = SRC_A_PC;
                        end
                        if (cls != ALU_REG)
                        begin
                            dp_sel.src_b = SRC_B_IMM;
                        end
                    end
                    JAL, JALR:
                    begin
                        dp_sel.src_a       = SRC_A_PC;     // Link value PC + 4
                        dp_sel.src_b       = SRC_B_FOUR;
                        dp_sel.pc_base_reg = (cls == JALR);
                        reg_write          = 1'b1;
                        pc_enable          = 1'b1;
                        pc_jump            = 1'b1;
                        state_next         = JUMP_SETTLE;
                    end
                    BRANCH:
                    begin
                        pc_enable  = 1'b1;                 // Compare rs1 with rs2
                        pc_jump    = 1'b1;
                        state_next = READY;
                    end
                    LOAD, STORE:
                    begin
                        dp_sel.src_b = SRC_B_IMM;          // Address rs1 + imm
                        dmem.req     = 1'b1;
                        dmem.we      = (cls == STORE);
                        dmem.be      = be;
                        if (data_gnt)
                        begin
                            state_next = (cls == STORE) ? STORE_DONE : LOAD_WAIT;
                        end
                    end
                    default: state_next = READY;           // No PC update
                endcase
            end
            WRITEBACK:
            begin
                pc_enable  = 1'b1;
                state_next = READY;
            end
            JUMP_SETTLE: state_next = READY;
            LOAD_WAIT:
            begin
                dp_sel.src_b  = SRC_B_IMM;
                dp_sel.wb_sel = WB_MEM;
                if (data_r_valid)
                begin
                    if (split)
                    begin
                        merge_write = 1'b1;                // Keep the low part
                        state_next  = LOAD_SECOND;
                    end
                    else
                    begin
                        reg_write  = 1'b1;
                        state_next = WRITEBACK;
                    end
                end
            end
            LOAD_SECOND:
            begin
                dp_sel.src_b = SRC_B_IMM;
                dmem.req     = 1'b1;
                dmem.be      = be;
                dmem.second  = 1'b1;
                if (data_gnt)
                begin
                    state_next = LOAD_SECOND_WAIT;
                end
            end
            LOAD_SECOND_WAIT:
            begin
                dp_sel.wb_sel = WB_MERGED;
                if (data_r_valid)
                begin
                    reg_write  = 1'b1;
                    state_next = WRITEBACK;
                end
            end
            STORE_DONE:
            begin
                dp_sel.src_b = SRC_B_IMM;
                if (split)
                begin
                    dmem.req    = 1'b1;
                    dmem.we     = 1'b1;
                    dmem.be     = be;
                    dmem.second = 1'b1;
                    if (data_gnt)
                    begin
                        state_next = STORE_SECOND;
                    end
                end
                else
                begin
                    pc_enable  = 1'b1;
                    state_next = READY;
                end
            end
            STORE_SECOND:
            begin
                pc_enable  = 1'b1;
                state_next = READY;
            end
            default: state_next = READY;
        endcase
    end

endmodule

/* src/ctrl_pkg.sv */
`include "ctrl_cfg.svh"

package ctrl_pkg;

    //////////////////////////////
    // Decode results
    //////////////////////////////

    typedef enum logic [3:0] {
        LUI,
        AUIPC,
        ALU_IMM,
        ALU_REG,
        JAL,
        JALR,
        BRANCH,
        LOAD,
        STORE,
        ILLEGAL
    } instr_class_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } access_size_e;

    // Sequencer states
    typedef enum logic [3:0] {
        READY,
        FETCH,
        EXECUTE,
        WRITEBACK,
        JUMP_SETTLE,      // Jumps already moved the PC
        LOAD_WAIT,
        LOAD_SECOND,
        LOAD_SECOND_WAIT,
        STORE_DONE,
        STORE_SECOND
    } ctrl_state_e;

    //////////////////////////////
    // Datapath controls
    //////////////////////////////

    typedef enum logic [1:0] {SRC_A_REG, SRC_A_PC, SRC_A_ZERO} src_a_e;
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} src_b_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_MERGED} wb_sel_e;

    typedef struct packed {
        src_a_e  src_a;
        src_b_e  src_b;
        wb_sel_e wb_sel;
        logic    pc_base_reg; // Jump target relative to rs1
    } datapath_sel_t;

    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [`CTRL_LANES-1:0] be;
        logic                   second; // Address of the next word
    } mem_req_t;

endpackage

/* src/ctrl_top.sv */
`include "ctrl_cfg.svh"

module ctrl_top
(
    input  logic                      CLK,
    input  logic                      RES,
    input  logic [`CTRL_OPCODE_W-1:0] opcode,
    input  logic [`CTRL_FUNCT3_W-1:0] funct3,
    input  logic [`CTRL_OFFSET_W-1:0] offset,      // Low address bits
    input  logic                      instr_gnt,
    input  logic                      instr_r_valid,
    input  logic                      data_gnt,
    input  logic                      data_r_valid,
    output logic                      instr_req,
    output logic                      pc_enable,
    output logic                      pc_jump,
    output logic                      reg_write,
    output logic                      merge_write,
    output ctrl_pkg::datapath_sel_t   dp_sel,
    output ctrl_pkg::mem_req_t        dmem
);
    import ctrl_pkg::*;

    instr_class_e           cls;
    access_size_e           size;
    logic [`CTRL_LANES-1:0] be;
    logic                   split;
    logic                   second_phase;

    instr_decoder u_decoder
    (
        .opcode (opcode),
        .funct3 (funct3),
        .cls    (cls),
        .size   (size)
    );

    lane_mask u_lane_mask
    (
        .size         (size),
        .offset       (offset),
        .second_phase (second_phase),
        .be           (be),
        .split        (split)
    );

    ctrl_fsm u_fsm
    (
        .CLK           (CLK),
        .RES           (RES),
        .cls           (cls),
        .split         (split),
        .be            (be),
        .instr_gnt     (instr_gnt),
        .instr_r_valid (instr_r_valid),
        .data_gnt      (data_gnt),
        .data_r_valid  (data_r_valid),
        .second_phase  (second_phase),
        .instr_req     (instr_req),
        .pc_enable     (pc_enable),
        .pc_jump       (pc_jump),
        .reg_write     (reg_write),
        .merge_write   (merge_write),
        .dp_sel        (dp_sel),
        .dmem          (dmem)
    );

endmodule

/* src/instr_decoder.sv */
`include "ctrl_cfg.svh"

module instr_decoder
(
    input  logic [`CTRL_OPCODE_W-1:0] opcode,
    input  logic [`CTRL_FUNCT3_W-1:0] funct3,
    output ctrl_pkg::instr_class_e    cls,
    output ctrl_pkg::access_size_e    size
);
    import ctrl_pkg::*;

    logic load_ok;
    logic store_ok;

    // Access width from funct3, bit 2 is only the load sign
    always_comb
    begin
        size    = WORD;
        load_ok = 1'b1;
        case (funct3)
            3'b000, 3'b100: size = BYTE;
            3'b001, 3'b101: size = HALF;
            3'b010:         size = WORD;
            default:        load_ok = 1'b0;
        endcase
    end

    // Stores have no unsigned variants
    assign store_ok = load_ok && !funct3[2];

    //////////////////////////////
    // Opcode to class
    //////////////////////////////
    always_comb
    begin
        case (opcode)
            `CTRL_OP_LUI:    cls = LUI;
            `CTRL_OP_AUIPC:  cls = AUIPC;
            `CTRL_OP_IMM:    cls = ALU_IMM;
            `CTRL_OP_REG:    cls = ALU_REG;
            `CTRL_OP_JAL:    cls = JAL;
            `CTRL_OP_JALR:   cls = JALR;
            `CTRL_OP_BRANCH: cls = BRANCH;
            `CTRL_OP_LOAD:
            begin
                cls = load_ok ? LOAD : ILLEGAL;
            end
            `CTRL_OP_STORE:
            begin
                cls = store_ok ? STORE : ILLEGAL;
            end
            default:         cls = ILLEGAL;
        endcase
    end

endmodule

/* src/lane_mask.sv */
`include "ctrl_cfg.svh"

module lane_mask
(
    input  ctrl_pkg::access_size_e     size,
    input  logic [`CTRL_OFFSET_W-1:0]  offset,
    input  logic                       second_phase,
    output logic [`CTRL_LANES-1:0]     be,
    output logic                       split
);
    import ctrl_pkg::*;

    logic [2*`CTRL_LANES-1:0] width_mask;
    logic [2*`CTRL_LANES-1:0] span;

    // Contiguous lanes covered by the access, starting at lane 0
    always_comb
    begin
        width_mask = '0;
        case (size)
            BYTE:    width_mask[0]   = 1'b1;
            HALF:    width_mask[1:0] = 2'b11;
            default: width_mask[`CTRL_LANES-1:0] = {`CTRL_LANES{1'b1}};
        endcase
    end

    // Lanes over two words; the upper half spills into the next word
    assign span = width_mask << offset;

    //////////////////////////////
    // Phase select
    //////////////////////////////
    assign split = |span[2*`CTRL_LANES-1:`CTRL_LANES];

    always_comb
    begin
        if (second_phase)
        begin
            be = span[2*`CTRL_LANES-1:`CTRL_LANES]; // Remainder from lane 0
        end
        else
        begin
            be = span[`CTRL_LANES-1:0];
        end
    end

endmodule
